/* sim.f */
+incdir+common
common/img_pkg.sv
common/img_ifs.sv
design/img_cmd_decoder.sv
pixel_unit/img_pixel_unit.sv
design/img_host_transfer.sv
design/image_processing.sv
testbench/image_processing_assert.sv
testbench/image_processing_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = image_processing_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/image_processing_tb.sv */
// testbench for the image coprocessor
// uploads images, runs a table of pixel operations and checks the read-back
`include "img_params.svh"

module image_processing_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROWS   = 10;
   localparam int WIDTH      = 8;
   localparam int HEIGHT     = 4;
   localparam int NUM_PIX    = WIDTH * HEIGHT;
   localparam int POLL_LIMIT = 100;

   // op, three parameter bytes, pixel data mix
   typedef struct packed {
      img_pkg::cmd_e op;
      logic [7:0]    b0;
      logic [7:0]    b1;
      logic [7:0]    b2;
      logic [7:0]    seed;
   } row_t;

   row_t rows [NUM_ROWS] = '{
      '{img_pkg::APPLY_ADD,       8'h64, 8'h00, 8'h00, 8'h00},   // +100, wraps
      '{img_pkg::APPLY_ADD,       8'h64, 8'h00, 8'h01, 8'h5a},   // +100, clamp
      '{img_pkg::APPLY_ADD,       8'hc4, 8'hff, 8'h01, 8'ha5},   // -60, clamp
      '{img_pkg::APPLY_ADD,       8'hc4, 8'hff, 8'h00, 8'h3c},   // -60, wraps
      '{img_pkg::APPLY_THRESHOLD, 8'h80, 8'h00, 8'h01, 8'h0f},   // upper mode
      '{img_pkg::APPLY_THRESHOLD, 8'h40, 8'hff, 8'h00, 8'hf0},   // lower mode
      '{img_pkg::APPLY_INVERT,    8'h00, 8'h00, 8'h00, 8'h99},
      '{img_pkg::APPLY_MULT,      8'h18, 8'h01, 8'h00, 8'h66},   // 1.5, clamp
      '{img_pkg::APPLY_MULT,      8'h2c, 8'h00, 8'h00, 8'hc3},   // 2.75, wraps
      '{img_pkg::APPLY_MULT,      8'h0c, 8'h01, 8'h00, 8'h11}    // 0.75
   };

   logic                   clk;
   logic                   rst_n;
   logic [`IMG_ADDR_W-1:0] addr;
   logic                   wr_en;
   logic                   rd_en;
   logic [`IMG_WORD_W-1:0] data_write;
   logic [`IMG_WORD_W-1:0] data_read = '0;
   logic                   data_read_valid = 1'b0;
   logic [`IMG_PIX_W-1:0]  comm_cmd;
   logic [`IMG_PIX_W-1:0]  comm_data_in;
   logic                   comm_data_in_valid;
   logic [`IMG_PIX_W-1:0]  comm_data_out;
   logic                   comm_data_out_valid;

   logic [`IMG_WORD_W-1:0] mem [0:65535];   // 128 KiB
   logic                   rd_pend = 1'b0;
   logic [`IMG_WORD_W-1:0] rd_word = '0;
   logic [7:0]             img [NUM_PIX];
   logic [7:0]             got [NUM_PIX];
   int                     errors;
   int                     checks;

   image_processing uut (
      .clk                 (clk),
      .rst_n               (rst_n),
      .addr                (addr),
      .wr_en               (wr_en),
      .rd_en               (rd_en),
      .data_write          (data_write),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid),
      .comm_cmd            (comm_cmd),
      .comm_data_in        (comm_data_in),
      .comm_data_in_valid  (comm_data_in_valid),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // memory model answers a word one cycle after rd_en
   always @(negedge clk) begin
      if (!rst_n) begin
         rd_pend         <= 1'b0;
         data_read_valid <= 1'b0;
      end else begin
         data_read_valid <= rd_pend;
         data_read       <= rd_word;
         rd_pend         <= rd_en;
         if (rd_en) rd_word <= mem[addr[16:1]];
         if (wr_en) mem[addr[16:1]] <= data_write;
      end
   end

   initial begin
      repeat (NUM_ROWS * 2000) @(posedge clk);
      $display("watchdog expired before the run completed");
      $display("tests failed");
      $finish;
   end

   function automatic logic [7:0] ref_pixel(input row_t r, input logic [7:0] p);
      int s;
      int v;
      ref_pixel = p;
      case (r.op)
         img_pkg::APPLY_ADD: begin
            s = int'($signed({r.b1, r.b0})) + int'(p);
            if (r.b2[0]) ref_pixel = (s < 0) ? 8'd0 : (s > 255) ? 8'd255 : 8'(s);
            else ref_pixel = 8'(s);                          // low byte only
         end
         img_pkg::APPLY_THRESHOLD: begin
            if (r.b2[0] ? (p >= r.b0) : (p <= r.b0)) ref_pixel = r.b1;
         end
         img_pkg::APPLY_INVERT: ref_pixel = ~p;
         img_pkg::APPLY_MULT: begin
            v = (int'(p) * int'(r.b0)) >> `IMG_FIX_FRAC;
            if (r.b1[0] && v > 255) ref_pixel = 8'd255;
            else ref_pixel = 8'(v);
         end
         default: ;
      endcase
   endfunction

   task automatic check_value(input string what, input int idx, input logic [7:0] got_v,
                              input logic [7:0] exp_v);
      checks++;
      if (got_v !== exp_v) begin
         errors++;
         $display("ERROR at %0t ns: %s byte %0d is %0d, expected %0d",
                  $time, what, idx, got_v, exp_v);
      end
   endtask

   task automatic drive_byte(input logic [7:0] c, input logic [7:0] d);
      @(negedge clk);
      comm_cmd           = c;
      comm_data_in       = d;
      comm_data_in_valid = 1'b1;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         comm_data_in_valid = 1'b0;
      end
   endtask

   task automatic read_status(output logic [7:0] first);
      logic [7:0] exp_b;
      int         i;
      first = 8'h00;
      drive_byte(img_pkg::GET_STATUS, 8'h00);
      for (i = 0; i < 5; i++) begin
         @(negedge clk);
         comm_data_in_valid = 1'b0;
         if (i == 4) begin
            if (comm_data_out_valid) begin
               errors++;
               $display("status reply ran past four bytes at %0t ns", $time);
            end
         end else if (!comm_data_out_valid) begin
            errors++;
            $display("status byte %0d did not arrive in its cycle at %0t ns", i, $time);
         end else if (i == 0) begin
            first = comm_data_out;
            check_value("status", 0, first & 8'hfe, `IMG_STATUS_B0 & 8'hfe);
         end else begin
            exp_b = (i == 1) ? `IMG_STATUS_B1 : (i == 2) ? `IMG_STATUS_B2 : `IMG_STATUS_B3;
            check_value("status", i, comm_data_out, exp_b);
         end
      end
   endtask

   task automatic set_size();
      drive_byte(img_pkg::PARAM, 8'h00);
      drive_byte(img_pkg::PARAM, 8'(WIDTH));
      drive_byte(img_pkg::PARAM, 8'(WIDTH >> 8));
      drive_byte(img_pkg::PARAM, 8'(HEIGHT));
      drive_byte(img_pkg::PARAM, 8'(HEIGHT >> 8));
      idle(2);
   endtask

   task automatic send_image();
      int i;
      drive_byte(img_pkg::SEND_IMG, 8'h00);
      for (i = 0; i < NUM_PIX; i++) drive_byte(img_pkg::SEND_IMG, img[i]);
      idle(3);   // decoder leaves its send state after the last write
   endtask

   task automatic read_image();
      int n;
      int waited;
      n      = 0;
      waited = 0;
      drive_byte(img_pkg::READ_IMG, 8'h00);
      while (n < NUM_PIX && waited < 20 * NUM_PIX) begin
         @(negedge clk);
         comm_data_in_valid = 1'b0;
         if (comm_data_out_valid) begin
            got[n] = comm_data_out;
            n++;
         end
         waited++;
      end
      if (n < NUM_PIX) begin
         errors++;
         $display("read-back stalled after %0d of %0d bytes", n, NUM_PIX);
      end
      idle(3);
   endtask

   task automatic switch_buffers();
      drive_byte(img_pkg::SWITCH_BUFFERS, 8'h00);
      idle(2);
   endtask

   task automatic start_op(input row_t r);
      drive_byte(r.op, 8'h00);
      case (r.op)
         img_pkg::APPLY_ADD, img_pkg::APPLY_THRESHOLD: begin
            drive_byte(r.op, r.b0);
            drive_byte(r.op, r.b1);
            drive_byte(r.op, r.b2);
         end
         img_pkg::APPLY_MULT: begin
            drive_byte(r.op, r.b0);
            drive_byte(r.op, r.b1);
         end
         default: ;                                 // invert starts on the opcode
      endcase
   endtask

   initial begin
      int         r;
      int         i;
      int         polls;
      logic [7:0] first;
      void'($urandom(32'hbdf7f391));
      errors             = 0;
      checks             = 0;
      rst_n              = 1'b0;
      comm_cmd           = '0;
      comm_data_in       = '0;
      comm_data_in_valid = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      checks++;
      if (comm_data_out_valid !== 1'b0 || wr_en !== 1'b0 || rd_en !== 1'b0) begin
         errors++;
         $display("ERROR at %0t ns: host or memory strobe high after reset", $time);
      end
      read_status(first);
      check_value("idle status", 0, first, `IMG_STATUS_B0 & 8'hfe);

      for (r = 0; r < NUM_ROWS; r++) begin
         for (i = 0; i < NUM_PIX; i++) img[i] = 8'($urandom) ^ rows[r].seed;
         set_size();
         send_image();
         read_image();                              // plain echo of the input buffer
         for (i = 0; i < NUM_PIX; i++) check_value("echo", i, got[i], img[i]);
         switch_buffers();
         start_op(rows[r]);
         read_status(first);                        // asked right after the start
         check_value("busy status", 0, first, `IMG_STATUS_B0);
         polls = 0;
         while (first[0] && polls < POLL_LIMIT) begin
            idle(2);
            read_status(first);
            polls++;
         end
         if (first[0]) begin
            errors++;
            $display("row %0d: operation still busy after %0d status polls", r, polls);
         end
         switch_buffers();
         read_image();
         for (i = 0; i < NUM_PIX; i++)
            check_value("result", i, got[i], ref_pixel(rows[r], img[i]));
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) $display("all tests passed");
      else $display("tests failed");
      $finish;
   end

endmodule

/* testbench/image_processing_assert.sv */
// protocol checks on the host transfer block
// memory strobes, address alignment and host output after reset
`include "img_params.svh"

module image_processing_assert (
   input logic                   clk,
   input logic                   rst_n,
   input logic [`IMG_ADDR_W-1:0] addr,
   input logic                   wr_en,
   input logic                   rd_en,
   input logic                   comm_data_out_valid
);
   timeunit 1ns;
   timeprecision 1ps;

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
      else $error("memory read and write strobes high together");

   // word accesses only
   addr_even: assert property (@(posedge clk) disable iff (!rst_n) (wr_en || rd_en) |-> !addr[0])
      else $error("odd memory address on a strobe");

   out_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !comm_data_out_valid)
      else $error("host output valid right after reset");

endmodule

bind img_host_transfer image_processing_assert u_assert (
   .clk                 (clk),
   .rst_n               (rst_n),
   .addr                (addr),
   .wr_en               (wr_en),
   .rd_en               (rd_en),
   .comm_data_out_valid (comm_data_out_valid)
);

/* design/image_processing.sv */
// image coprocessor top level
// byte-serial host link in, two image buffers in external 16-bit memory
`include "img_params.svh"

module image_processing (
   input  logic                   clk,
   input  logic                   rst_n,
   output logic [`IMG_ADDR_W-1:0] addr,
   output logic                   wr_en,
   output logic                   rd_en,
   output logic [`IMG_WORD_W-1:0] data_write,
   input  logic [`IMG_WORD_W-1:0] data_read,
   input  logic                   data_read_valid,
   input  logic [`IMG_PIX_W-1:0]  comm_cmd,
   input  logic [`IMG_PIX_W-1:0]  comm_data_in,
   input  logic                   comm_data_in_valid,
   output logic [`IMG_PIX_W-1:0]  comm_data_out,
   output logic                   comm_data_out_valid
);

   img_mem_if  mem ();
   img_proc_if proc ();
   img_xfer_if xfer ();

   img_cmd_decoder u_decoder (
      .clk                (clk),
      .rst_n              (rst_n),
      .comm_cmd           (comm_cmd),
      .comm_data_in       (comm_data_in),
      .comm_data_in_valid (comm_data_in_valid),
      .proc               (proc),
      .xfer               (xfer)
   );

   img_pixel_unit u_pixel (
      .clk   (clk),
      .rst_n (rst_n),
      .proc  (proc),
      .mem   (mem)
   );

   // transfer block arbitrates the external memory port
   img_host_transfer u_xfer (
      .clk                 (clk),
      .rst_n               (rst_n),
      .xfer                (xfer),
      .proc_mem            (mem),
      .busy                (proc.busy),
      .addr                (addr),
      .wr_en               (wr_en),
      .rd_en               (rd_en),
      .data_write          (data_write),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid),
      .comm_data_in        (comm_data_in),
      .comm_data_in_valid  (comm_data_in_valid),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid)
   );

endmodule

/* design/img_host_transfer.sv */
// host transfer block
// image upload and read-back, status reply, and owner of the memory port
`include "img_params.svh"

module img_host_transfer (
   input  logic                   clk,
   input  logic                   rst_n,
   img_xfer_if.transfer           xfer,
   img_mem_if.port                proc_mem,
   input  logic                   busy,
   output logic [`IMG_ADDR_W-1:0] addr,
   output logic                   wr_en,
   output logic                   rd_en,
   output logic [`IMG_WORD_W-1:0] data_write,
   input  logic [`IMG_WORD_W-1:0] data_read,
   input  logic                   data_read_valid,
   input  logic [`IMG_PIX_W-1:0]  comm_data_in,
   input  logic                   comm_data_in_valid,
   output logic [`IMG_PIX_W-1:0]  comm_data_out,
   output logic                   comm_data_out_valid
);

   localparam logic [`IMG_PIX_W-1:0] status_b0 = `IMG_STATUS_B0;

   img_pkg::xfer_state_e   state;
   logic [`IMG_DIM_W-1:0]  left;         // bytes still to move
   logic [`IMG_ADDR_W-1:0] ptr;          // byte address
   logic [`IMG_ADDR_W-1:0] h_addr;
   logic [`IMG_WORD_W-1:0] h_data;
   logic                   h_wr;
   logic                   h_rd;
   logic                   rd_wait;      // word requested, not back yet
   logic                   hi_pend;      // high byte still to send
   logic [`IMG_PIX_W-1:0]  hi_byte;
   logic [1:0]             step;
   logic                   own;

   // status reply does not need memory, so the pixel unit keeps running
   assign own         = state == img_pkg::XFER_SEND || state == img_pkg::XFER_READ || h_wr;
   assign xfer.active = (state != img_pkg::XFER_IDLE) || h_wr;

   assign addr       = own ? h_addr : proc_mem.addr;
   assign wr_en      = own ? h_wr : proc_mem.wr_en;
   assign rd_en      = own ? h_rd : proc_mem.rd_en;
   assign data_write = own ? h_data : proc_mem.data_write;
   assign proc_mem.data_read       = data_read;
   assign proc_mem.data_read_valid = data_read_valid && !own;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= img_pkg::XFER_IDLE;
         left <= '0;
         ptr <= '0;
         h_addr <= '0;
         h_data <= '0;
         h_wr <= 1'b0;
         h_rd <= 1'b0;
         rd_wait <= 1'b0;
         hi_pend <= 1'b0;
         hi_byte <= '0;
         step <= '0;
         comm_data_out <= '0;
         comm_data_out_valid <= 1'b0;
      end else begin
         h_wr <= 1'b0;
         h_rd <= 1'b0;
         comm_data_out_valid <= 1'b0;
         case (state)
            img_pkg::XFER_IDLE: begin
               ptr  <= xfer.base;
               left <= xfer.count;
               if (xfer.send_start) state <= img_pkg::XFER_SEND;
               else if (xfer.read_start) state <= img_pkg::XFER_READ;
               else if (xfer.status_start) begin
                  comm_data_out <= {status_b0[`IMG_PIX_W-1:1], busy};   // bit0 is busy
                  comm_data_out_valid <= 1'b1;
                  step  <= 2'd1;
                  state <= img_pkg::XFER_STATUS;
               end
            end
            img_pkg::XFER_SEND: begin
               if (comm_data_in_valid) begin
                  if (!ptr[0]) begin
                     h_data[`IMG_PIX_W-1:0] <= comm_data_in;
                  end else begin
                     h_data[`IMG_WORD_W-1:`IMG_PIX_W] <= comm_data_in;
                     h_addr <= {ptr[`IMG_ADDR_W-1:1], 1'b0};
                     h_wr   <= 1'b1;           // pair complete
                  end
                  ptr  <= ptr + 1'b1;
                  left <= left - 1'b1;
                  if (left <= 1) state <= img_pkg::XFER_IDLE;
               end
            end
            img_pkg::XFER_READ: begin
               if (hi_pend) begin
                  comm_data_out       <= hi_byte;
                  comm_data_out_valid <= 1'b1;
                  hi_pend <= 1'b0;
                  ptr     <= ptr + 2'd2;
                  left    <= left - 2'd2;
                  if (left <= 2) state <= img_pkg::XFER_IDLE;
               end else if (rd_wait) begin
                  if (data_read_valid) begin
                     comm_data_out       <= data_read[`IMG_PIX_W-1:0];   // low byte first
                     comm_data_out_valid <= 1'b1;
                     hi_byte <= data_read[`IMG_WORD_W-1:`IMG_PIX_W];
                     rd_wait <= 1'b0;
                     hi_pend <= 1'b1;
                  end
               end else begin
                  h_addr  <= ptr;
                  h_rd    <= 1'b1;
                  rd_wait <= 1'b1;
               end
            end
            default: begin
               comm_data_out_valid <= 1'b1;
               step <= step + 1'b1;
               case (step)
                  2'd1: comm_data_out <= `IMG_STATUS_B1;
                  2'd2: comm_data_out <= `IMG_STATUS_B2;
                  default: begin
                     comm_data_out <= `IMG_STATUS_B3;
                     state <= img_pkg::XFER_IDLE;
                  end
               endcase
            end
         endcase
      end
   end

endmodule

/* pixel_unit/img_pixel_unit.sv */
// per-pixel operation engine
// read-modify-write over the storage buffer, two pixels per word
`include "img_params.svh"

module img_pixel_unit (
   input  logic         clk,
   input  logic         rst_n,
   img_proc_if.unit     proc,
   img_mem_if.requester mem
);

   img_pkg::pix_state_e    state;
   logic [`IMG_ADDR_W-1:0] ptr;
   logic [`IMG_DIM_W-1:0]  left;        // pixels still to do

   function automatic logic [`IMG_PIX_W-1:0] pix_fn(input logic [`IMG_PIX_W-1:0] p);
      logic [`IMG_WORD_W-1:0] sum;
      logic [`IMG_WORD_W-1:0] prod;
      sum    = proc.add_value + p;
      prod   = p * proc.mult_value;
      pix_fn = p;
      case (proc.op)
         img_pkg::OP_ADD: begin
            pix_fn = sum[`IMG_PIX_W-1:0];
            if (proc.clamp && $signed(sum) < 0) pix_fn = '0;
            else if (proc.clamp && $signed(sum) > 255) pix_fn = '1;
         end
         img_pkg::OP_THRESH: begin
            if (proc.thresh_upper ? (p >= proc.thresh_value) : (p <= proc.thresh_value))
               pix_fn = proc.thresh_repl;
         end
         img_pkg::OP_INVERT: pix_fn = ~p;
         default: begin
            pix_fn = prod[`IMG_FIX_FRAC +: `IMG_PIX_W];      // drop fraction bits
            if (proc.clamp && |prod[`IMG_WORD_W-1:`IMG_FIX_FRAC+`IMG_PIX_W]) pix_fn = '1;
         end
      endcase
   endfunction

   // busy covers the final write strobe
   assign proc.busy = (state != img_pkg::PIX_IDLE) || mem.wr_en;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= img_pkg::PIX_IDLE;
         ptr       <= '0;
         left      <= '0;
         mem.rd_en <= 1'b0;
         mem.wr_en <= 1'b0;
      end else begin
         mem.rd_en <= 1'b0;
         mem.wr_en <= 1'b0;
         case (state)
            img_pkg::PIX_IDLE: begin
               if (proc.start) begin
                  ptr   <= proc.base;
                  left  <= proc.count;
                  state <= img_pkg::PIX_READ;
               end
            end
            img_pkg::PIX_READ: begin
               mem.rd_en <= 1'b1;
               state     <= img_pkg::PIX_WRITE;
            end
            img_pkg::PIX_WRITE: begin
               if (mem.data_read_valid) begin
                  mem.wr_en <= 1'b1;
                  ptr       <= ptr + 2'd2;
                  left      <= left - 2'd2;
                  state     <= (left <= 2) ? img_pkg::PIX_IDLE : img_pkg::PIX_READ;
               end
            end
            default: state <= img_pkg::PIX_IDLE;
         endcase
      end
   end

   // write goes back to the word just read
   always_ff @(posedge clk) begin
      if (state == img_pkg::PIX_READ) mem.addr <= ptr;
      if (state == img_pkg::PIX_WRITE && mem.data_read_valid)
         mem.data_write <= {pix_fn(mem.data_read[`IMG_WORD_W-1:`IMG_PIX_W]),
                            pix_fn(mem.data_read[`IMG_PIX_W-1:0])};
   end

endmodule

/* design/img_cmd_decoder.sv */
// host command decoder
// takes opcodes and parameter bytes, holds image size and buffer bases,
// and issues operation and transfer start pulses
`include "img_params.svh"

module img_cmd_decoder (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`IMG_PIX_W-1:0] comm_cmd,
   input  logic [`IMG_PIX_W-1:0] comm_data_in,
   input  logic                  comm_data_in_valid,
   img_proc_if.decoder           proc,
   img_xfer_if.decoder           xfer
);

   img_pkg::dec_state_e    state;
   img_pkg::cmd_e          cmd;
   logic [1:0]             idx;         // parameter byte index
   logic [`IMG_DIM_W-1:0]  width;
   logic [`IMG_DIM_W-1:0]  height;
   logic [`IMG_DIM_W-1:0]  pix_count;
   logic [`IMG_ADDR_W-1:0] in_base;
   logic [`IMG_ADDR_W-1:0] st_base;
   logic                   skip;        // op command came in while busy
   logic                   cmd_cycle;
   logic                   last_byte;

   assign cmd       = img_pkg::cmd_e'(comm_cmd);
   assign cmd_cycle = (state == img_pkg::DEC_WAIT) && comm_data_in_valid;
   assign pix_count = width * height;

   // flags byte closes every operation
   assign last_byte = comm_data_in_valid &&
                      (((state == img_pkg::DEC_ADD || state == img_pkg::DEC_THRESH) && idx == 2'd2) ||
                       (state == img_pkg::DEC_MULT && idx == 2'd1));

   assign proc.start = (last_byte && !skip) ||
                       (cmd_cycle && cmd == img_pkg::APPLY_INVERT && !proc.busy);
   assign proc.base  = st_base;
   assign proc.count = pix_count;

   assign xfer.send_start   = cmd_cycle && cmd == img_pkg::SEND_IMG && !proc.busy;
   assign xfer.read_start   = cmd_cycle && cmd == img_pkg::READ_IMG && !proc.busy;
   assign xfer.status_start = cmd_cycle && cmd == img_pkg::GET_STATUS;
   assign xfer.base         = in_base;
   assign xfer.count        = pix_count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= img_pkg::DEC_WAIT;
         idx     <= '0;
         width   <= '0;
         height  <= '0;
         in_base <= `IMG_BUF0_BASE;
         st_base <= `IMG_BUF1_BASE;
         skip    <= 1'b0;
      end else begin
         case (state)
            img_pkg::DEC_WAIT: begin
               idx <= '0;
               if (comm_data_in_valid) begin
                  skip <= proc.busy;
                  case (cmd)
                     img_pkg::PARAM:           state <= img_pkg::DEC_DIMS;
                     img_pkg::SEND_IMG:        if (!proc.busy) state <= img_pkg::DEC_SEND;
                     img_pkg::APPLY_ADD:       state <= img_pkg::DEC_ADD;
                     img_pkg::APPLY_THRESHOLD: state <= img_pkg::DEC_THRESH;
                     img_pkg::APPLY_MULT:      state <= img_pkg::DEC_MULT;
                     img_pkg::SWITCH_BUFFERS: begin
                        in_base <= st_base;
                        st_base <= in_base;
                     end
                     default: ;                // read, status and invert have no bytes
                  endcase
               end
            end
            img_pkg::DEC_SEND: if (!xfer.active) state <= img_pkg::DEC_WAIT;
            img_pkg::DEC_DIMS: if (comm_data_in_valid) begin
               idx <= idx + 1'b1;
               case (idx)
                  2'd0: width[`IMG_PIX_W-1:0]            <= comm_data_in;
                  2'd1: width[`IMG_DIM_W-1:`IMG_PIX_W]   <= comm_data_in;
                  2'd2: height[`IMG_PIX_W-1:0]           <= comm_data_in;
                  default: begin
                     height[`IMG_DIM_W-1:`IMG_PIX_W] <= comm_data_in;
                     state <= img_pkg::DEC_WAIT;
                  end
               endcase
            end
            default: if (comm_data_in_valid) begin
               idx <= idx + 1'b1;
               if (last_byte) state <= img_pkg::DEC_WAIT;
            end
         endcase
      end
   end

   // operation parameters stay put while an operation runs
   always_ff @(posedge clk) begin
      if (cmd_cycle && !proc.busy) begin
         case (cmd)
            img_pkg::APPLY_ADD:       proc.op <= img_pkg::OP_ADD;
            img_pkg::APPLY_THRESHOLD: proc.op <= img_pkg::OP_THRESH;
            img_pkg::APPLY_INVERT:    proc.op <= img_pkg::OP_INVERT;
            img_pkg::APPLY_MULT:      proc.op <= img_pkg::OP_MULT;
            default: ;
         endcase
      end
      if (comm_data_in_valid && !skip) begin
         case (state)
            img_pkg::DEC_ADD: begin
               case (idx)
                  2'd0:    proc.add_value[`IMG_PIX_W-1:0]          <= comm_data_in;
                  2'd1:    proc.add_value[`IMG_WORD_W-1:`IMG_PIX_W] <= comm_data_in;
                  default: proc.clamp <= comm_data_in[0];
               endcase
            end
            img_pkg::DEC_THRESH: begin
               case (idx)
                  2'd0:    proc.thresh_value <= comm_data_in;
                  2'd1:    proc.thresh_repl  <= comm_data_in;
                  default: proc.thresh_upper <= comm_data_in[0];
               endcase
            end
            img_pkg::DEC_MULT: begin
               if (idx == 2'd0) proc.mult_value <= comm_data_in;
               else proc.clamp <= comm_data_in[0];
            end
            default: ;
         endcase
      end
   end

endmodule

/* common/img_ifs.sv */
// image coprocessor interfaces
// memory requests, pixel operation control and host transfer control
`include "img_params.svh"

interface img_mem_if;
   logic [`IMG_ADDR_W-1:0] addr;
   logic                   wr_en;
   logic                   rd_en;
   logic [`IMG_WORD_W-1:0] data_write;
   logic [`IMG_WORD_W-1:0] data_read;
   logic                   data_read_valid;

   modport requester (output addr, wr_en, rd_en, data_write, input data_read, data_read_valid);
   modport port (input addr, wr_en, rd_en, data_write, output data_read, data_read_valid);
endinterface

interface img_proc_if;
   logic                   start;         // one cycle
   img_pkg::pix_op_e       op;
   logic [`IMG_ADDR_W-1:0] base;          // storage buffer
   logic [`IMG_DIM_W-1:0]  count;
   logic [`IMG_WORD_W-1:0] add_value;
   logic                   clamp;
   logic [`IMG_PIX_W-1:0]  thresh_value;
   logic [`IMG_PIX_W-1:0]  thresh_repl;
   logic                   thresh_upper;
   logic [`IMG_PIX_W-1:0]  mult_value;    // 4.4 fixed point
   logic                   busy;

   modport decoder (output start, op, base, count, add_value, clamp, thresh_value,
                    thresh_repl, thresh_upper, mult_value, input busy);
   modport unit (input start, op, base, count, add_value, clamp, thresh_value,
                 thresh_repl, thresh_upper, mult_value, output busy);
endinterface

interface img_xfer_if;
   logic                   send_start;
   logic                   read_start;
   logic                   status_start;
   logic [`IMG_ADDR_W-1:0] base;          // input buffer
   logic [`IMG_DIM_W-1:0]  count;
   logic                   active;

   modport decoder (output send_start, read_start, status_start, base, count, input active);
   modport transfer (input send_start, read_start, status_start, base, count, output active);
endinterface

/* common/img_pkg.sv */
// image coprocessor types
// host opcodes, pixel operations and the FSM state encodings
`include "img_params.svh"

package img_pkg;

   // codes in the gaps are unused
   typedef enum logic [`IMG_PIX_W-1:0] {
      PARAM           = 0,
      SEND_IMG        = 1,
      READ_IMG        = 2,
      GET_STATUS      = 3,
      APPLY_ADD       = 4,
      APPLY_THRESHOLD = 5,
      SWITCH_BUFFERS  = 6,
      APPLY_INVERT    = 8,
      APPLY_MULT      = 14
   } cmd_e;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_THRESH,
      OP_INVERT,
      OP_MULT
   } pix_op_e;

   typedef enum logic [2:0] {
      DEC_WAIT,
      DEC_DIMS,
      DEC_ADD,
      DEC_THRESH,
      DEC_MULT,
      DEC_SEND
   } dec_state_e;

   typedef enum logic [1:0] {
      XFER_IDLE,
      XFER_SEND,
      XFER_READ,
      XFER_STATUS
   } xfer_state_e;

   typedef enum logic [1:0] {
      PIX_IDLE,
      PIX_READ,
      PIX_WRITE
   } pix_state_e;

endpackage

/* common/img_params.svh */
// image coprocessor parameters
// widths, buffer memory map and status reply bytes
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

`define IMG_PIX_W      8
`define IMG_WORD_W     16
`define IMG_ADDR_W     32
`define IMG_DIM_W      16

// two buffers, each half of the 128 KiB memory
`define IMG_BUF0_BASE  32'h0000_0000
`define IMG_BUF1_BASE  32'h0001_0000

`define IMG_STATUS_B0  8'd11
`define IMG_STATUS_B1  8'd22
`define IMG_STATUS_B2  8'd33
`define IMG_STATUS_B3  8'd44

`define IMG_FIX_FRAC   4

`endif
